//--- hdl/qupls_ucode_pkg.sv
// Widths, instruction typedefs, opcodes, registers, ROM rows and selector enums
package qupls_ucode_pkg;

  // ====================
  // Widths and types
  // ====================
  localparam int unsigned INSTR_W = 40;
  localparam int unsigned REG_W   = 6;
  localparam int unsigned IMM_W   = 13;
  localparam int unsigned OPC_W   = 7;

  typedef logic [INSTR_W-1:0]   instr_t;   // Macro instruction or micro-op
  typedef logic [REG_W-1:0]     reg_t;     // Register number
  typedef logic [IMM_W-1:0]     imm_t;     // Two's complement immediate
  typedef logic [OPC_W-1:0]     opcode_t;
  typedef logic [5:0]           row_t;     // ROM row, micro address is row * 4
  typedef logic [2:0]           cnt_t;     // PUSH/POP register count
  typedef logic signed [3:0]    gate_t;    // Count index of slot 0 in a gated row

  // Field positions inside an instruction word
  localparam int unsigned F_RT  = 7;
  localparam int unsigned F_RA  = 13;
  localparam int unsigned F_RB  = 19;
  localparam int unsigned F_RC  = 25;
  localparam int unsigned F_RD  = 31;
  localparam int unsigned F_IMM = 19;   // Micro-op immediate 31:19
  localparam int unsigned F_CNT = 37;

  // ====================
  // Opcodes
  // ====================
  localparam opcode_t MOP_ENTER  = 7'h68;
  localparam opcode_t MOP_LEAVE  = 7'h69;
  localparam opcode_t MOP_PUSH   = 7'h6A;
  localparam opcode_t MOP_POP    = 7'h6B;
  localparam opcode_t MOP_RSTVEC = 7'h6F;

  localparam opcode_t OP_NOP  = 7'h00;  // All-zero micro-op is a NOP
  localparam opcode_t OP_ADDI = 7'h04;
  localparam opcode_t OP_ORI  = 7'h0E;
  localparam opcode_t OP_STO  = 7'h5A;
  localparam opcode_t OP_LDO  = 7'h4A;
  localparam opcode_t OP_JSR  = 7'h20;

  // Architectural registers touched by the sequences
  localparam reg_t REG_SP   = 6'd63;
  localparam reg_t REG_FP   = 6'd62;
  localparam reg_t REG_LR1  = 6'd57;
  localparam reg_t REG_MC0  = 6'd48;
  localparam reg_t REG_ZERO = 6'd0;

  // ====================
  // Sequencer constants
  // ====================
  localparam int SLOTS       = 4;
  localparam int FRAME_BYTES = 64;
  localparam int SLOT_BYTES  = 16;
  localparam imm_t VEC_SP    = imm_t'(-32);   // Reset stack pointer vector
  localparam imm_t VEC_PC    = imm_t'(-16);   // Reset program counter vector

  localparam row_t ROW_END    = 6'd0;   // End of chain, also unknown macro
  localparam row_t ROW_ENTER  = 6'd1;
  localparam row_t ROW_LEAVE  = 6'd4;
  localparam row_t ROW_PUSH   = 6'd8;
  localparam row_t ROW_POP    = 6'd12;
  localparam row_t ROW_RSTVEC = 6'd60;

  localparam gate_t GATE_NONE = gate_t'(-8);  // Row has no count gating

  // Source of a slot's rt field
  typedef enum logic [2:0] {FS_FIXED, FS_RT, FS_RA, FS_RB, FS_RC, FS_RD} field_sel_t;
  // Source of a slot's immediate
  typedef enum logic [1:0] {IS_FIXED, IS_MACRO, IS_PUSH_ADJ, IS_POP_ADJ} imm_sel_t;

  // Pack a micro-op, upper bits zero
  function automatic instr_t mk_uop(opcode_t op, reg_t rt, reg_t ra, imm_t imm);
    return {8'd0, imm, ra, rt, op};
  endfunction

endpackage

//--- hdl/ucode_if.sv
// Row request and row data interfaces between the sequencer stages
`timescale 1ns/1ps

// ====================
// Entry to ROM
// ====================
interface row_req_if import qupls_ucode_pkg::*; ();
  logic   valid;     // One row per valid cycle
  row_t   row;
  instr_t ir;        // Macro word that owns this row
  row_t   next_row;  // Chain link, looked up from row
  logic   last;      // Row ends its chain

  modport entry (output valid, row, ir, input next_row, last);
  modport rom   (input valid, row, ir, output next_row, last);
endinterface

// ====================
// ROM to expand
// ====================
interface row_data_if import qupls_ucode_pkg::*; ();
  logic       valid;
  instr_t     ir;
  instr_t     tmpl0, tmpl1, tmpl2, tmpl3;   // Slot templates
  field_sel_t rsel0, rsel1, rsel2, rsel3;   // rt substitution per slot
  imm_sel_t   isel0, isel1, isel2, isel3;   // Immediate substitution per slot
  gate_t      gate_base;

  modport source (
    output valid, ir, tmpl0, tmpl1, tmpl2, tmpl3,
    output rsel0, rsel1, rsel2, rsel3, isel0, isel1, isel2, isel3, gate_base
  );
  modport sink (
    input valid, ir, tmpl0, tmpl1, tmpl2, tmpl3,
    input rsel0, rsel1, rsel2, rsel3, isel0, isel1, isel2, isel3, gate_base
  );
endinterface

//--- hdl/ucode_entry.sv
// Macro acceptance, entry row lookup and row chain walker
`timescale 1ns/1ps

module ucode_entry import qupls_ucode_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ir_valid,
  input  instr_t   macro_ir,
  output logic     busy,
  row_req_if.entry req
);

  typedef enum logic {IDLE, RUN} state_t;

  state_t state;
  row_t   row_q;       // Row being issued this cycle
  instr_t ir_q;        // Held macro word
  row_t   entry_row;   // First row for the incoming opcode
  logic   start;

  // Opcode to entry row map
  always_comb begin
    case (opcode_t'(macro_ir))
      MOP_ENTER:  entry_row = ROW_ENTER;
      MOP_LEAVE:  entry_row = ROW_LEAVE;
      MOP_PUSH:   entry_row = ROW_PUSH;
      MOP_POP:    entry_row = ROW_POP;
      MOP_RSTVEC: entry_row = ROW_RSTVEC;
      default:    entry_row = ROW_END;   // Unknown macro, nothing to run
    endcase
  end

  // Busy drops while the last row goes out so the next macro lines up behind it
  assign busy  = (state == RUN) && !req.last;
  assign start = ir_valid && !busy && (entry_row != ROW_END);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      row_q <= ROW_END;
    end else if (busy) begin
      row_q <= req.next_row;          // Step along the chain
    end else if (start) begin
      state <= RUN;                   // Also covers back-to-back restart
      row_q <= entry_row;
    end else begin
      state <= IDLE;
      row_q <= ROW_END;
    end
  end

  always_ff @(posedge clk) begin
    if (start) ir_q <= macro_ir;      // Capture only on a real start
  end

  assign req.valid = (state == RUN);
  assign req.row   = row_q;
  assign req.ir    = ir_q;

endmodule

//--- hdl/ucode_rom.sv
// Micro-code row table with chain links and registered slot templates
`timescale 1ns/1ps

module ucode_rom import qupls_ucode_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  row_req_if.rom      req,
  row_data_if.source  dat
);

  instr_t     tmpl [SLOTS];
  field_sel_t rsel [SLOTS];
  imm_sel_t   isel [SLOTS];
  gate_t      gate;
  row_t       nxt;
  logic       last;

  // ====================
  // Row table
  // ====================
  always_comb begin
    for (int s = 0; s < SLOTS; s++) begin
      tmpl[s] = mk_uop(OP_NOP, REG_ZERO, REG_ZERO, '0);   // Idle slot
      rsel[s] = FS_FIXED;
      isel[s] = IS_FIXED;
    end
    gate = GATE_NONE;
    nxt  = ROW_END;
    last = 1'b1;                                         // Unused rows end the chain
    case (req.row)
      ROW_ENTER: begin                                   // Frame alloc and saves
        tmpl[0] = mk_uop(OP_ADDI, REG_SP, REG_SP, imm_t'(-FRAME_BYTES));
        tmpl[1] = mk_uop(OP_STO, REG_FP, REG_SP, '0);
        tmpl[2] = mk_uop(OP_STO, REG_LR1, REG_SP, imm_t'(SLOT_BYTES));
        tmpl[3] = mk_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(2 * SLOT_BYTES));
        nxt     = row_t'(ROW_ENTER + 1);
        last    = 1'b0;
      end
      row_t'(ROW_ENTER + 1): begin
        tmpl[0] = mk_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(3 * SLOT_BYTES));
        tmpl[1] = mk_uop(OP_ORI, REG_FP, REG_SP, '0);    // FP = SP
        tmpl[2] = mk_uop(OP_ADDI, REG_SP, REG_SP, '0);
        isel[2] = IS_MACRO;                              // Local space from macro
      end
      ROW_LEAVE: begin                                   // Unwind the frame
        tmpl[0] = mk_uop(OP_ORI, REG_SP, REG_FP, '0);
        tmpl[1] = mk_uop(OP_LDO, REG_FP, REG_SP, '0);
        tmpl[2] = mk_uop(OP_LDO, REG_LR1, REG_SP, imm_t'(SLOT_BYTES));
        tmpl[3] = mk_uop(OP_ADDI, REG_SP, REG_SP, imm_t'(FRAME_BYTES));
        nxt     = row_t'(ROW_LEAVE + 1);
        last    = 1'b0;
      end
      row_t'(ROW_LEAVE + 1): begin
        tmpl[0] = mk_uop(OP_ADDI, REG_SP, REG_SP, '0);
        isel[0] = IS_MACRO;                              // Drop caller arguments
        tmpl[1] = mk_uop(OP_JSR, REG_ZERO, REG_LR1, '0); // Return through LR1
      end
      ROW_PUSH: begin
        tmpl[0] = mk_uop(OP_ADDI, REG_SP, REG_SP, '0);
        isel[0] = IS_PUSH_ADJ;
        tmpl[1] = mk_uop(OP_STO, REG_ZERO, REG_SP, '0);
        rsel[1] = FS_RT;
        tmpl[2] = mk_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(SLOT_BYTES));
        rsel[2] = FS_RA;
        tmpl[3] = mk_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(2 * SLOT_BYTES));
        rsel[3] = FS_RB;
        gate    = gate_t'(-1);                           // Slot 1 holds k = 0
        nxt     = row_t'(ROW_PUSH + 1);
        last    = 1'b0;
      end
      row_t'(ROW_PUSH + 1): begin
        tmpl[0] = mk_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(3 * SLOT_BYTES));
        rsel[0] = FS_RC;
        tmpl[1] = mk_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(4 * SLOT_BYTES));
        rsel[1] = FS_RD;
        gate    = gate_t'(3);
      end
      ROW_POP: begin
        tmpl[0] = mk_uop(OP_LDO, REG_ZERO, REG_SP, '0);
        rsel[0] = FS_RT;
        tmpl[1] = mk_uop(OP_LDO, REG_ZERO, REG_SP, imm_t'(SLOT_BYTES));
        rsel[1] = FS_RA;
        tmpl[2] = mk_uop(OP_LDO, REG_ZERO, REG_SP, imm_t'(2 * SLOT_BYTES));
        rsel[2] = FS_RB;
        tmpl[3] = mk_uop(OP_LDO, REG_ZERO, REG_SP, imm_t'(3 * SLOT_BYTES));
        rsel[3] = FS_RC;
        gate    = gate_t'(0);
        nxt     = row_t'(ROW_POP + 1);
        last    = 1'b0;
      end
      row_t'(ROW_POP + 1): begin
        tmpl[0] = mk_uop(OP_LDO, REG_ZERO, REG_SP, imm_t'(4 * SLOT_BYTES));
        rsel[0] = FS_RD;
        tmpl[1] = mk_uop(OP_ADDI, REG_SP, REG_SP, '0);   // Fixed rt so never gated
        isel[1] = IS_POP_ADJ;
        gate    = gate_t'(4);
      end
      ROW_RSTVEC: begin                                  // Fetch vectors and jump
        tmpl[0] = mk_uop(OP_LDO, REG_SP, REG_ZERO, VEC_SP);
        tmpl[1] = mk_uop(OP_LDO, REG_MC0, REG_ZERO, VEC_PC);
        tmpl[2] = mk_uop(OP_JSR, REG_ZERO, REG_MC0, '0);
      end
      default: ;
    endcase
  end

  assign req.next_row = nxt;
  assign req.last     = last;

  // ====================
  // Output register
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n) dat.valid <= 1'b0;
    else        dat.valid <= req.valid;
  end

  always_ff @(posedge clk) begin
    if (req.valid) begin
      dat.ir        <= req.ir;
      dat.tmpl0     <= tmpl[0];
      dat.tmpl1     <= tmpl[1];
      dat.tmpl2     <= tmpl[2];
      dat.tmpl3     <= tmpl[3];
      dat.rsel0     <= rsel[0];
      dat.rsel1     <= rsel[1];
      dat.rsel2     <= rsel[2];
      dat.rsel3     <= rsel[3];
      dat.isel0     <= isel[0];
      dat.isel1     <= isel[1];
      dat.isel2     <= isel[2];
      dat.isel3     <= isel[3];
      dat.gate_base <= gate;
    end
  end

endmodule

//--- hdl/ucode_expand.sv
// Field substitution, count gating and micro-op output register
`timescale 1ns/1ps

module ucode_expand import qupls_ucode_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  row_data_if.sink  dat,
  output logic      uop_valid,
  output instr_t    uop0,
  output instr_t    uop1,
  output instr_t    uop2,
  output instr_t    uop3
);

  // Build one micro-op from its template and the macro word
  function automatic instr_t fill_slot(instr_t tmpl, field_sel_t rsel, imm_sel_t isel,
                                       gate_t gbase, int slot, instr_t mir);
    instr_t u;
    cnt_t   n;
    imm_t   adj;
    gate_t  k;
    u   = tmpl;
    n   = mir[F_CNT +: $bits(cnt_t)];
    adj = imm_t'(n * SLOT_BYTES);       // N slots worth of bytes
    k   = gbase + gate_t'(slot);

    // rt always receives the chosen macro register
    case (rsel)
      FS_RT:   u[F_RT +: REG_W] = mir[F_RT +: REG_W];
      FS_RA:   u[F_RT +: REG_W] = mir[F_RA +: REG_W];
      FS_RB:   u[F_RT +: REG_W] = mir[F_RB +: REG_W];
      FS_RC:   u[F_RT +: REG_W] = mir[F_RC +: REG_W];
      FS_RD:   u[F_RT +: REG_W] = mir[F_RD +: REG_W];
      default: ;
    endcase

    case (isel)
      IS_MACRO:    u[F_IMM +: IMM_W] = mir[F_IMM +: IMM_W];
      IS_PUSH_ADJ: u[F_IMM +: IMM_W] = -adj;   // Grow stack down
      IS_POP_ADJ:  u[F_IMM +: IMM_W] = adj;
      default: ;
    endcase

    // Only register slots count, SP adjusts always pass
    if (gbase != GATE_NONE && rsel != FS_FIXED && k >= gate_t'({1'b0, n}))
      u = instr_t'(OP_NOP);
    return u;
  endfunction

  // ====================
  // Output stage
  // ====================
  always_ff @(posedge clk) begin
    if (!rst_n) uop_valid <= 1'b0;
    else        uop_valid <= dat.valid;
  end

  always_ff @(posedge clk) begin
    if (dat.valid) begin
      uop0 <= fill_slot(dat.tmpl0, dat.rsel0, dat.isel0, dat.gate_base, 0, dat.ir);
      uop1 <= fill_slot(dat.tmpl1, dat.rsel1, dat.isel1, dat.gate_base, 1, dat.ir);
      uop2 <= fill_slot(dat.tmpl2, dat.rsel2, dat.isel2, dat.gate_base, 2, dat.ir);
      uop3 <= fill_slot(dat.tmpl3, dat.rsel3, dat.isel3, dat.gate_base, 3, dat.ir);
    end
  end

endmodule

//--- hdl/qupls_ucode_seq.sv
// Top level of the stack-frame micro-code sequencer, three pipeline stages
`timescale 1ns/1ps

module qupls_ucode_seq import qupls_ucode_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   ir_valid,    // One-cycle macro strobe
  input  instr_t macro_ir,
  output logic   busy,        // Further rows pending in the entry stage
  output logic   uop_valid,
  output instr_t uop0,
  output instr_t uop1,
  output instr_t uop2,
  output instr_t uop3
);

  row_req_if  req_if ();      // Entry to ROM
  row_data_if dat_if ();      // ROM to expand

  ucode_entry u_entry (
    .clk      (clk),
    .rst_n    (rst_n),
    .ir_valid (ir_valid),
    .macro_ir (macro_ir),
    .busy     (busy),
    .req      (req_if.entry)
  );

  ucode_rom u_rom (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req_if.rom),
    .dat   (dat_if.source)
  );

  ucode_expand u_expand (
    .clk       (clk),
    .rst_n     (rst_n),
    .dat       (dat_if.sink),
    .uop_valid (uop_valid),
    .uop0      (uop0),
    .uop1      (uop1),
    .uop2      (uop2),
    .uop3      (uop3)
  );

endmodule

//--- sim/ucode_seq_asserts.sv
// Concurrent assertions on the sequencer top level and their bind
`timescale 1ns/1ps

module ucode_seq_asserts (
  input logic clk,
  input logic rst_n,
  input logic ir_valid,
  input logic busy,
  input logic uop_valid
);

  // ====================
  // Reset
  // ====================
  // Synchronous reset, so outputs are low from the second reset edge
  a_reset_quiet: assert property (@(posedge clk) (!rst_n ##1 !rst_n) |-> !busy && !uop_valid)
    else $error("busy or uop_valid high during reset");

  a_release_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !uop_valid [*3])
    else $error("uop_valid high right after reset release");

  // ====================
  // Chain control
  // ====================
  // Every chain has at most one non-last row, a restart would hold busy
  a_stray_dropped: assert property (@(posedge clk) disable iff (!rst_n)
    busy && ir_valid |=> !busy)
    else $error("strobe during busy restarted a chain");

  a_last_row_out: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> ##2 uop_valid)   // Last row two stages behind
    else $error("last row missing after busy fell");

endmodule

bind qupls_ucode_seq ucode_seq_asserts u_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .ir_valid  (ir_valid),
  .busy      (busy),
  .uop_valid (uop_valid)
);

//--- sim/tb_ucode_seq.sv
// Testbench for the micro-code sequencer with stimulus table, reference model and watchdog
`timescale 1ns/1ps

module tb_ucode_seq import qupls_ucode_pkg::*; ();

  localparam int TAB_LEN = 17;
  localparam int CLK_NS  = 20;

  // One table line with random register fields and immediate
  typedef struct packed {
    opcode_t    opc;
    cnt_t       cnt;
    logic [2:0] rows;   // Rows this macro yields on its own
    logic [1:0] mode;   // 0 alone, 1 next line back-to-back, 2 stray strobe while busy
  } stim_t;

  logic   clk;
  logic   rst_n;
  logic   ir_valid;
  instr_t macro_ir;
  logic   busy;
  logic   uop_valid;
  instr_t uop0, uop1, uop2, uop3;

  stim_t  tab [TAB_LEN];
  instr_t exp_q [$];    // Expected slots in arrival order with four per row
  int     n_checks;
  int     n_errors;
  int     n_tests;

  qupls_ucode_seq dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .ir_valid  (ir_valid),
    .macro_ir  (macro_ir),
    .busy      (busy),
    .uop_valid (uop_valid),
    .uop0      (uop0),
    .uop1      (uop1),
    .uop2      (uop2),
    .uop3      (uop3)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // ====================
  // Reference model
  // ====================
  function automatic instr_t pack_uop(opcode_t op, reg_t rt, reg_t ra, imm_t imm);
    instr_t u;
    u        = '0;
    u[6:0]   = op;
    u[12:7]  = rt;    // Destination or store source
    u[18:13] = ra;    // Base register
    u[31:19] = imm;
    return u;
  endfunction

  // Macro register for count index k
  function automatic reg_t macro_reg(instr_t m, int k);
    case (k)
      0:       return m[12:7];
      1:       return m[18:13];
      2:       return m[24:19];
      3:       return m[30:25];
      default: return m[36:31];
    endcase
  endfunction

  // Expected micro-op at position idx = row * 4 + slot of the chain
  function automatic instr_t ref_slot(instr_t m, int idx);
    int     n;
    instr_t u;
    n = int'(m[39:37]);
    u = '0;                                       // NOP unless a rule below fires
    case (m[6:0])
      MOP_ENTER: case (idx)
        0: u = pack_uop(OP_ADDI, REG_SP, REG_SP, imm_t'(-64));
        1: u = pack_uop(OP_STO, REG_FP, REG_SP, imm_t'(0));
        2: u = pack_uop(OP_STO, REG_LR1, REG_SP, imm_t'(16));
        3: u = pack_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(32));
        4: u = pack_uop(OP_STO, REG_ZERO, REG_SP, imm_t'(48));
        5: u = pack_uop(OP_ORI, REG_FP, REG_SP, imm_t'(0));
        6: u = pack_uop(OP_ADDI, REG_SP, REG_SP, m[31:19]);
        default: ;
      endcase
      MOP_LEAVE: case (idx)
        0: u = pack_uop(OP_ORI, REG_SP, REG_FP, imm_t'(0));
        1: u = pack_uop(OP_LDO, REG_FP, REG_SP, imm_t'(0));
        2: u = pack_uop(OP_LDO, REG_LR1, REG_SP, imm_t'(16));
        3: u = pack_uop(OP_ADDI, REG_SP, REG_SP, imm_t'(64));
        4: u = pack_uop(OP_ADDI, REG_SP, REG_SP, m[31:19]);
        5: u = pack_uop(OP_JSR, REG_ZERO, REG_LR1, imm_t'(0));
        default: ;
      endcase
      MOP_PUSH: begin
        if (idx == 0)
          u = pack_uop(OP_ADDI, REG_SP, REG_SP, imm_t'(-16 * n));
        else if (idx - 1 < n && idx - 1 < 5)     // Store k = idx - 1
          u = pack_uop(OP_STO, macro_reg(m, idx - 1), REG_SP, imm_t'(16 * (idx - 1)));
      end
      MOP_POP: begin
        if (idx == 5)
          u = pack_uop(OP_ADDI, REG_SP, REG_SP, imm_t'(16 * n));
        else if (idx < n && idx < 5)              // Load k = idx
          u = pack_uop(OP_LDO, macro_reg(m, idx), REG_SP, imm_t'(16 * idx));
      end
      MOP_RSTVEC: case (idx)
        0: u = pack_uop(OP_LDO, REG_SP, REG_ZERO, imm_t'(-32));
        1: u = pack_uop(OP_LDO, REG_MC0, REG_ZERO, imm_t'(-16));
        2: u = pack_uop(OP_JSR, REG_ZERO, REG_MC0, imm_t'(0));
        default: ;
      endcase
      default: ;                                  // Unknown macro has no rows
    endcase
    return u;
  endfunction

  function automatic instr_t make_macro(stim_t t);
    instr_t m;
    m        = '0;
    m[36:7]  = 30'($urandom());   // Random rt..rd and immediate
    m[39:37] = t.cnt;
    m[6:0]   = t.opc;
    return m;
  endfunction

  task automatic queue_rows(input instr_t m, input int rows);
    for (int i = 0; i < rows * SLOTS; i++)
      exp_q.push_back(ref_slot(m, i));
  endtask

  // ====================
  // Checks
  // ====================
  task automatic check_true(input logic cond, input string msg);
    n_checks++;
    assert (cond) else begin
      $display("error %0t: %s", $time, msg);
      n_errors++;
    end
  endtask

  task automatic compare_uop(input instr_t got, input instr_t exp, input int slot);
    n_checks++;
    assert (got === exp) else begin
      $display("error %0t: slot %0d got %h expected %h", $time, slot, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_row();
    if (exp_q.size() < SLOTS) begin
      check_true(1'b0, "uop_valid high with no row expected");
    end else begin
      compare_uop(uop0, exp_q.pop_front(), 0);
      compare_uop(uop1, exp_q.pop_front(), 1);
      compare_uop(uop2, exp_q.pop_front(), 2);
      compare_uop(uop3, exp_q.pop_front(), 3);
    end
  endtask

  task automatic load_table();
    tab[0] = '{MOP_ENTER, 3'd0, 3'd2, 2'd0};
    tab[1] = '{MOP_LEAVE, 3'd0, 3'd2, 2'd0};
    for (int n = 1; n <= 5; n++) begin
      tab[1 + n] = '{MOP_PUSH, cnt_t'(n), 3'd2, 2'd0};
      tab[6 + n] = '{MOP_POP, cnt_t'(n), 3'd2, 2'd0};
    end
    tab[12] = '{MOP_RSTVEC, 3'd0, 3'd1, 2'd0};
    tab[13] = '{MOP_ENTER, 3'd0, 3'd2, 2'd1};    // Followed directly by line 14
    tab[14] = '{MOP_POP, 3'd3, 3'd2, 2'd0};
    tab[15] = '{MOP_LEAVE, 3'd0, 3'd2, 2'd2};
    tab[16] = '{7'h7F, 3'd0, 3'd0, 2'd0};        // Unknown opcode
  endtask

  // Runs one table line between two falling edges
  task automatic run_entry(input int i, output int next_i);
    stim_t  t;
    stim_t  stray;
    int     cyc, got, first_at, last_at, limit, err0;
    logic   busy_seen, sent2, done;
    t        = tab[i];
    stray    = '{MOP_PUSH, 3'd5, 3'd2, 2'd0};
    err0     = n_errors;
    cyc      = 0;
    got      = 0;
    first_at = -1;
    last_at  = -1;
    busy_seen = 1'b0;
    sent2    = 1'b0;
    done     = 1'b0;
    limit    = (t.rows == 0) ? 4 : 12;           // Row wait bound in cycles
    exp_q.delete();
    check_true(!busy, "busy high before a new macro was driven");
    macro_ir = make_macro(t);
    queue_rows(macro_ir, t.rows);
    ir_valid = 1'b1;
    while (!done) begin
      @(negedge clk);
      cyc++;
      ir_valid = 1'b0;
      if (busy) busy_seen = 1'b1;
      if (uop_valid) begin
        if (first_at < 0) first_at = cyc;
        last_at = cyc;
        got++;
        check_row();
      end
      if (t.mode == 2'd1 && busy_seen && !busy && !sent2) begin
        macro_ir = make_macro(tab[i + 1]);       // Cycle after busy falls
        queue_rows(macro_ir, tab[i + 1].rows);
        ir_valid = 1'b1;
        sent2    = 1'b1;
      end
      if (t.mode == 2'd2 && cyc == 1) begin
        check_true(busy, "busy low when the stray strobe was driven");
        macro_ir = make_macro(stray);            // Must be dropped
        ir_valid = 1'b1;
      end
      done = (cyc >= limit) || (got > 0 && !uop_valid && exp_q.size() == 0);
    end
    check_true(exp_q.size() == 0, "timeout while waiting for the expected rows");
    if (t.rows > 0)
      check_true(first_at == 3, "first row not 3 cycles after acceptance");
    check_true(got == 0 || last_at - first_at + 1 == got, "gap between output rows");
    if (t.rows <= 1)
      check_true(!busy_seen, "busy rose for a macro without further rows");
    else
      check_true(busy_seen, "busy never rose for a macro with further rows");
    if (t.mode == 2'd1)
      check_true(sent2, "second macro never driven because busy did not fall");
    repeat (2) begin                             // Trailing idle window
      @(negedge clk);
      check_true(!uop_valid, "extra row after the sequence ended");
    end
    $display("test %0d opcode %h count %0d rows %0d: %s", i, t.opc, t.cnt, got,
             (n_errors == err0) ? "ok" : "mismatch");
    next_i = (t.mode == 2'd1) ? i + 2 : i + 1;
  endtask

  // ====================
  // Main sequence
  // ====================
  initial begin
    int i;
    int nxt;
    void'($urandom(32'h85a9));
    clk      = 1'b0;
    rst_n    = 1'b0;
    ir_valid = 1'b0;
    macro_ir = '0;
    n_checks = 0;
    n_errors = 0;
    n_tests  = 0;
    load_table();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    check_true(!busy && !uop_valid, "busy or uop_valid high after reset");
    i = 0;
    while (i < TAB_LEN) begin
      run_entry(i, nxt);
      n_tests++;
      i = nxt;
    end
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #(2 * TAB_LEN * 8 * CLK_NS);
    $display("Watchdog expired before the tests completed");
    $display("Checks failed");
    $finish;
  end

endmodule

//--- compile.f
hdl/qupls_ucode_pkg.sv
hdl/ucode_if.sv
hdl/ucode_entry.sv
hdl/ucode_rom.sv
hdl/ucode_expand.sv
hdl/qupls_ucode_seq.sv
sim/ucode_seq_asserts.sv
sim/tb_ucode_seq.sv

//--- Bender.yml
package:
  name: qupls_ucode_seq

sources:
  - hdl/qupls_ucode_pkg.sv
  - hdl/ucode_if.sv
  - hdl/ucode_entry.sv
  - hdl/ucode_rom.sv
  - hdl/ucode_expand.sv
  - hdl/qupls_ucode_seq.sv
  - target: simulation
    files:
      - sim/ucode_seq_asserts.sv
      - sim/tb_ucode_seq.sv
